//--- verilog/dot_pkg.sv
`default_nettype none

package dot_pkg;

   // width of each I or Q part of an input sample.
   localparam int sample_w = 12;

   // product part width, 24-bit partial products plus one bit for the add.
   localparam int prod_w = 25;

   // running sum width. the sum wraps in this many bits.
   localparam int sum_w = 32;

   // result width per part, taken from the top of the sum.
   localparam int out_w = 24;

   // number of products summed into one result.
   localparam int dot_len = 5;

   // register stages in the complex multiplier.
   // operand, partial product and sum stage.
   localparam int mult_lat = 3;

endpackage

`default_nettype wire

//--- verilog/sample_rx.sv
`default_nettype none

module sample_rx #(
   parameter int sample_w = dot_pkg::sample_w
) (
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       req_i,
   input  logic signed [sample_w-1:0] xi_i,
   input  logic signed [sample_w-1:0] xq_i,
   input  logic signed [sample_w-1:0] yi_i,
   input  logic signed [sample_w-1:0] yq_i,
   input  logic                       ready_i,
   output logic                       ack_o,
   output logic                       valid_o,
   output logic signed [sample_w-1:0] xi_o,
   output logic signed [sample_w-1:0] xq_o,
   output logic signed [sample_w-1:0] yi_o,
   output logic signed [sample_w-1:0] yq_o
);

   logic req_s1;
   logic req_s2;
   logic capture;

   // source runs on its own timing, so req goes through two flops.
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         req_s1 <= 1'b0;
         req_s2 <= 1'b0;
      end else begin
         req_s1 <= req_i;
         req_s2 <= req_s1;
      end
   end

   // new pair only after the last ack returned to zero and the buffer drained.
   assign capture = req_s2 && !ack_o && !valid_o;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o   <= 1'b0;
         valid_o <= 1'b0;
      end else begin
         if (capture) begin
            ack_o   <= 1'b1;
            valid_o <= 1'b1;
         end else begin
            if (!req_s2)
               ack_o <= 1'b0; // return to zero.
            if (valid_o && ready_i)
               valid_o <= 1'b0; // taken by the multiplier.
         end
      end
   end

   // data is stable while req is high, so sampling it here is safe.
   always_ff @(posedge clk) begin
      if (capture) begin
         xi_o <= xi_i;
         xq_o <= xq_i;
         yi_o <= yi_i;
         yq_o <= yq_i;
      end
   end

endmodule

`default_nettype wire

//--- verilog/cpx_multiply.sv
`default_nettype none

module cpx_multiply #(
   parameter int sample_w = dot_pkg::sample_w,
   parameter int prod_w   = dot_pkg::prod_w
) (
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       valid_i,
   input  logic signed [sample_w-1:0] xi_i,
   input  logic signed [sample_w-1:0] xq_i,
   input  logic signed [sample_w-1:0] yi_i,
   input  logic signed [sample_w-1:0] yq_i,
   input  logic                       ready_i,
   output logic                       ready_o,
   output logic                       valid_o,
   output logic signed [prod_w-1:0]   pi_o,
   output logic signed [prod_w-1:0]   pq_o
);

   localparam int lat  = dot_pkg::mult_lat;
   localparam int pp_w = 2 * sample_w;

   logic [lat-1:0] vld;

   // stage 1 operands.
   logic signed [sample_w-1:0] s1_xi;
   logic signed [sample_w-1:0] s1_xq;
   logic signed [sample_w-1:0] s1_yi;
   logic signed [sample_w-1:0] s1_yq;

   // stage 2 partial products.
   logic signed [pp_w-1:0] pp_ii;
   logic signed [pp_w-1:0] pp_qq;
   logic signed [pp_w-1:0] pp_iq;
   logic signed [pp_w-1:0] pp_qi;

   // the whole pipe advances only when the consumer can take.
   assign ready_o = ready_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i)
         vld <= '0;
      else if (ready_i)
         vld <= {vld[lat-2:0], valid_i};
   end

   assign valid_o = vld[lat-1];

   always_ff @(posedge clk) begin
      if (ready_i) begin
         s1_xi <= xi_i;
         s1_xq <= xq_i;
         s1_yi <= yi_i;
         s1_yq <= yq_i;
      end
   end

   always_ff @(posedge clk) begin
      if (ready_i) begin
         pp_ii <= s1_xi * s1_yi;
         pp_qq <= s1_xq * s1_yq;
         pp_iq <= s1_xi * s1_yq;
         pp_qi <= s1_xq * s1_yi;
      end
   end

   // extend before the add so the extra bit holds the carry.
   always_ff @(posedge clk) begin
      if (ready_i) begin
         pi_o <= prod_w'(pp_ii) - prod_w'(pp_qq); // real part.
         pq_o <= prod_w'(pp_iq) + prod_w'(pp_qi); // imaginary part.
      end
   end

endmodule

`default_nettype wire

//--- verilog/dot_accumulate.sv
`default_nettype none

module dot_accumulate #(
   parameter int prod_w  = dot_pkg::prod_w,
   parameter int sum_w   = dot_pkg::sum_w,
   parameter int out_w   = dot_pkg::out_w,
   parameter int dot_len = dot_pkg::dot_len
) (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     valid_i,
   input  logic signed [prod_w-1:0] pi_i,
   input  logic signed [prod_w-1:0] pq_i,
   input  logic                     ready_i,
   output logic                     ready_o,
   output logic                     valid_o,
   output logic signed [out_w-1:0]  si_o,
   output logic signed [out_w-1:0]  sq_o
);

   localparam int cnt_w = (dot_len > 1) ? $clog2(dot_len) : 1;
   localparam int shift = sum_w - out_w;

   logic [cnt_w-1:0]        cnt;
   logic signed [sum_w-1:0] sum_i;
   logic signed [sum_w-1:0] sum_q;
   logic signed [sum_w-1:0] nxt_i;
   logic signed [sum_w-1:0] nxt_q;
   logic signed [sum_w-1:0] scl_i;
   logic signed [sum_w-1:0] scl_q;
   logic                    take;
   logic                    first;
   logic                    last;

   // blocked only while a finished result is still waiting.
   assign ready_o = !valid_o || ready_i;
   assign take    = valid_i && ready_o;
   assign first   = (cnt == '0);
   assign last    = (cnt == cnt_w'(dot_len - 1));

   // first product of a block loads, the rest add and wrap.
   assign nxt_i = first ? sum_w'(pi_i) : sum_i + sum_w'(pi_i);
   assign nxt_q = first ? sum_w'(pq_i) : sum_q + sum_w'(pq_i);

   assign scl_i = nxt_i >>> shift;
   assign scl_q = nxt_q >>> shift;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt   <= '0;
         sum_i <= '0;
         sum_q <= '0;
      end else if (take) begin
         sum_i <= nxt_i;
         sum_q <= nxt_q;
         cnt   <= last ? '0 : cnt + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i)
         valid_o <= 1'b0;
      else if (take && last)
         valid_o <= 1'b1;
      else if (ready_i)
         valid_o <= 1'b0; // result handed to the sender.
   end

   // keep the top out_w bits of the block sum.
   always_ff @(posedge clk) begin
      if (take && last) begin
         si_o <= scl_i[out_w-1:0];
         sq_o <= scl_q[out_w-1:0];
      end
   end

endmodule

`default_nettype wire

//--- verilog/result_tx.sv
`default_nettype none

module result_tx #(
   parameter int out_w = dot_pkg::out_w
) (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    valid_i,
   input  logic signed [out_w-1:0] si_i,
   input  logic signed [out_w-1:0] sq_i,
   input  logic                    res_ack_i,
   output logic                    ready_o,
   output logic                    res_req_o,
   output logic signed [out_w-1:0] res_i_o,
   output logic signed [out_w-1:0] res_q_o
);

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_hi   = 2'd1; // waiting for ack high.
   localparam logic [1:0] st_lo   = 2'd2; // waiting for ack low.

   logic [1:0] state;
   logic       ack_s1;
   logic       ack_s2;

   assign ready_o = (state == st_idle);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_s1 <= 1'b0;
         ack_s2 <= 1'b0;
      end else begin
         ack_s1 <= res_ack_i;
         ack_s2 <= ack_s1;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state     <= st_idle;
         res_req_o <= 1'b0;
      end else begin
         case (state)
            st_idle: if (valid_i) state <= st_hi;
            st_hi: begin
               if (ack_s2) begin
                  res_req_o <= 1'b0;
                  state     <= st_lo;
               end else begin
                  res_req_o <= 1'b1; // data already held a cycle.
               end
            end
            st_lo:   if (!ack_s2) state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (valid_i && ready_o) begin
         res_i_o <= si_i;
         res_q_o <= sq_i;
      end
   end

endmodule

`default_nettype wire

//--- verilog/dot_prod_top.sv
`default_nettype none

// result appears mult_lat cycles plus block and handshake time after the samples.
module dot_prod_top #(
   parameter int sample_w = dot_pkg::sample_w,
   parameter int prod_w   = dot_pkg::prod_w,
   parameter int sum_w    = dot_pkg::sum_w,
   parameter int out_w    = dot_pkg::out_w,
   parameter int dot_len  = dot_pkg::dot_len
) (
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       req_i,
   input  logic signed [sample_w-1:0] xi_i,
   input  logic signed [sample_w-1:0] xq_i,
   input  logic signed [sample_w-1:0] yi_i,
   input  logic signed [sample_w-1:0] yq_i,
   input  logic                       res_ack_i,
   output logic                       ack_o,
   output logic                       res_req_o,
   output logic signed [out_w-1:0]    res_i_o,
   output logic signed [out_w-1:0]    res_q_o
);

   logic                       rx_valid;
   logic                       mul_ready;
   logic signed [sample_w-1:0] rx_xi;
   logic signed [sample_w-1:0] rx_xq;
   logic signed [sample_w-1:0] rx_yi;
   logic signed [sample_w-1:0] rx_yq;

   logic                       mul_valid;
   logic                       acc_ready;
   logic signed [prod_w-1:0]   mul_pi;
   logic signed [prod_w-1:0]   mul_pq;

   logic                       acc_valid;
   logic                       tx_ready;
   logic signed [out_w-1:0]    acc_si;
   logic signed [out_w-1:0]    acc_sq;

   sample_rx #(.sample_w(sample_w)) u_rx (
      .clk     (clk),       .rst_n_i (rst_n_i),
      .req_i   (req_i),     .ack_o   (ack_o),
      .xi_i    (xi_i),      .xq_i    (xq_i),
      .yi_i    (yi_i),      .yq_i    (yq_i),
      .ready_i (mul_ready), .valid_o (rx_valid),
      .xi_o    (rx_xi),     .xq_o    (rx_xq),
      .yi_o    (rx_yi),     .yq_o    (rx_yq)
   );

   cpx_multiply #(.sample_w(sample_w), .prod_w(prod_w)) u_mul (
      .clk     (clk),       .rst_n_i (rst_n_i),
      .valid_i (rx_valid),  .ready_o (mul_ready),
      .xi_i    (rx_xi),     .xq_i    (rx_xq),
      .yi_i    (rx_yi),     .yq_i    (rx_yq),
      .ready_i (acc_ready), .valid_o (mul_valid),
      .pi_o    (mul_pi),    .pq_o    (mul_pq)
   );

   dot_accumulate #(
      .prod_w(prod_w), .sum_w(sum_w), .out_w(out_w), .dot_len(dot_len)
   ) u_acc (
      .clk     (clk),       .rst_n_i (rst_n_i),
      .valid_i (mul_valid), .ready_o (acc_ready),
      .pi_i    (mul_pi),    .pq_i    (mul_pq),
      .ready_i (tx_ready),  .valid_o (acc_valid),
      .si_o    (acc_si),    .sq_o    (acc_sq)
   );

   result_tx #(.out_w(out_w)) u_tx (
      .clk       (clk),       .rst_n_i   (rst_n_i),
      .valid_i   (acc_valid), .ready_o   (tx_ready),
      .si_i      (acc_si),    .sq_i      (acc_sq),
      .res_ack_i (res_ack_i), .res_req_o (res_req_o),
      .res_i_o   (res_i_o),   .res_q_o   (res_q_o)
   );

endmodule

`default_nettype wire

//--- bench/dot_prod_tb.sv
`default_nettype none

module dot_prod_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int smp_w    = dot_pkg::sample_w;
   localparam int acc_w    = dot_pkg::sum_w;
   localparam int res_w    = dot_pkg::out_w;
   localparam int blk_len  = dot_pkg::dot_len;
   localparam int wait_lim = 5000; // cycles allowed for any single wait.

   logic                    clk = 1'b0;
   logic                    rst_n_i;
   logic                    req_i;
   logic signed [smp_w-1:0] xi_i;
   logic signed [smp_w-1:0] xq_i;
   logic signed [smp_w-1:0] yi_i;
   logic signed [smp_w-1:0] yq_i;
   logic                    res_ack_i = 1'b0;
   logic                    ack_o;
   logic                    res_req_o;
   logic signed [res_w-1:0] res_i_o;
   logic signed [res_w-1:0] res_q_o;

   logic [blk_len-1:0][4*smp_w-1:0] blk; // pairs of the block being sent.
   int                              blk_n = 0;
   logic signed [res_w-1:0]         exp_i_q[$];
   logic signed [res_w-1:0]         exp_q_q[$];

   int   err_cnt       = 0;
   int   chk_cnt       = 0;
   int   res_cnt       = 0;
   int   test_num      = 0;
   int   test_err0     = 0;
   int   ack_delay_max = 0;
   int   max_ack_wait  = 0;
   int   dly           = -1;
   logic req_seen      = 1'b0;

   dot_prod_top dut (
      .clk       (clk),       .rst_n_i   (rst_n_i),
      .req_i     (req_i),     .ack_o     (ack_o),
      .xi_i      (xi_i),      .xq_i      (xq_i),
      .yi_i      (yi_i),      .yq_i      (yq_i),
      .res_ack_i (res_ack_i), .res_req_o (res_req_o),
      .res_i_o   (res_i_o),   .res_q_o   (res_q_o)
   );

   always #5 clk = ~clk;

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic report_error(input string what);
      err_cnt++;
      $display("ERROR %s", what);
   endtask

   // complex multiply each pair, sum with wrap, keep the top bits.
   function automatic logic [2*res_w-1:0] dot_ref(input logic [blk_len-1:0][4*smp_w-1:0] prs);
      logic signed [smp_w-1:0] xi;
      logic signed [smp_w-1:0] xq;
      logic signed [smp_w-1:0] yi;
      logic signed [smp_w-1:0] yq;
      int                      re;
      int                      im;
      logic signed [acc_w-1:0] acc_i;
      logic signed [acc_w-1:0] acc_q;
      acc_i = '0;
      acc_q = '0;
      for (int k = 0; k < blk_len; k++) begin
         {xi, xq, yi, yq} = prs[k];
         re = int'(xi) * int'(yi) - int'(xq) * int'(yq);
         im = int'(xi) * int'(yq) + int'(xq) * int'(yi);
         acc_i = acc_i + acc_w'(re);
         acc_q = acc_q + acc_w'(im);
      end
      acc_i = acc_i >>> (acc_w - res_w);
      acc_q = acc_q >>> (acc_w - res_w);
      return {acc_i[res_w-1:0], acc_q[res_w-1:0]};
   endfunction

   // one four-phase exchange on the input side.
   task automatic send_pair(input int xi, input int xq, input int yi, input int yq);
      int                 cycles;
      logic [2*res_w-1:0] ref_v;
      @(negedge clk);
      xi_i  = smp_w'(xi);
      xq_i  = smp_w'(xq);
      yi_i  = smp_w'(yi);
      yq_i  = smp_w'(yq);
      req_i = 1'b1;
      cycles = 0;
      while (!ack_o && cycles < wait_lim) begin
         @(negedge clk);
         cycles++;
      end
      if (!ack_o)
         report_error("timed out waiting for ack_o to rise");
      if (cycles > max_ack_wait)
         max_ack_wait = cycles;
      blk[blk_n] = {xi_i, xq_i, yi_i, yq_i};
      blk_n++;
      if (blk_n == blk_len) begin
         ref_v = dot_ref(blk);
         exp_i_q.push_back(ref_v[2*res_w-1:res_w]);
         exp_q_q.push_back(ref_v[res_w-1:0]);
         blk_n = 0;
      end
      req_i = 1'b0;
      cycles = 0;
      while (ack_o && cycles < wait_lim) begin
         @(negedge clk);
         cycles++;
      end
      if (ack_o)
         report_error("timed out waiting for ack_o to fall");
   endtask

   task automatic send_random_blocks(input int n);
      for (int b = 0; b < n; b++)
         for (int k = 0; k < blk_len; k++)
            send_pair($urandom, $urandom, $urandom, $urandom);
   endtask

   task automatic wait_results();
      int cycles;
      cycles = 0;
      while ((exp_i_q.size() != 0 || res_req_o || res_ack_i) && cycles < wait_lim) begin
         @(negedge clk);
         cycles++;
      end
      if (cycles >= wait_lim)
         report_error("timed out waiting for the outstanding results");
   endtask

   task automatic start_test();
      test_num++;
      test_err0 = err_cnt;
   endtask

   task automatic report_test(input string name);
      $display("test %0d %s: %s", test_num, name, (err_cnt == test_err0) ? "ok" : "failed");
   endtask

   // result consumer, raises ack after dly cycles and drops it after another delay.
   always @(negedge clk) begin
      if (!rst_n_i) begin
         res_ack_i <= 1'b0;
         dly = -1;
      end else if (res_req_o && !res_ack_i) begin
         if (dly < 0)
            dly = (ack_delay_max > 0) ?
                  int'($urandom_range(ack_delay_max, ack_delay_max / 2)) : 0;
         if (dly == 0) begin
            res_ack_i <= 1'b1;
            dly = -1;
         end else begin
            dly--;
         end
      end else if (!res_req_o && res_ack_i) begin
         if (dly < 0)
            dly = (ack_delay_max > 0) ? int'($urandom_range(ack_delay_max / 4, 1)) : 0;
         if (dly == 0) begin
            res_ack_i <= 1'b0; // a late drop exposes a request that does not wait.
            dly = -1;
         end else begin
            dly--;
         end
      end
   end

   // compares each result at the rise of res_req_o.
   always @(negedge clk) begin
      if (!rst_n_i) begin
         req_seen <= 1'b0;
      end else begin
         if (res_req_o && !req_seen) begin
            res_cnt++;
            check_val("res_ack_i", 64'(res_ack_i), 64'd0); // previous ack must be gone.
            if (exp_i_q.size() == 0) begin
               report_error("a result arrived with none expected");
            end else begin
               check_val("res_i_o", res_i_o, exp_i_q.pop_front());
               check_val("res_q_o", res_q_o, exp_q_q.pop_front());
            end
         end
         req_seen <= res_req_o;
      end
   end

   initial begin
      int res0;
      void'($urandom(40));
      rst_n_i = 1'b0;
      req_i   = 1'b0;
      xi_i    = '0;
      xq_i    = '0;
      yi_i    = '0;
      yq_i    = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;

      start_test();
      send_pair(100, 0, 3, 0);   // purely real.
      send_pair(0, 50, 0, -7);   // purely imaginary.
      send_pair(-1, 2, 3, -4);
      send_pair(1000, -1000, 500, 250);
      send_pair(-2048, 0, 0, 2047);
      wait_results();
      report_test("single fixed block");

      start_test();
      res0 = res_cnt;
      send_random_blocks(20);
      wait_results();
      check_val("result count", 64'(res_cnt - res0), 64'd20);
      report_test("streamed random blocks");

      start_test();
      for (int k = 0; k < blk_len; k++)
         send_pair(-2048, -2048, -2048, -2048);
      for (int k = 0; k < blk_len; k++) begin
         if (k % 2 == 0)
            send_pair(2047, -2048, 2047, -2048);
         else
            send_pair(-2048, 2047, 2047, -2048);
      end
      for (int k = 0; k < blk_len; k++)
         send_pair(2047, -2048, -2048, -2048); // large negative real part.
      wait_results();
      report_test("extreme values");

      start_test();
      res0 = res_cnt;
      ack_delay_max = 80;
      max_ack_wait  = 0;
      send_random_blocks(6);
      wait_results();
      ack_delay_max = 0;
      check_val("result count", 64'(res_cnt - res0), 64'd6);
      if (max_ack_wait < 20)
         report_error("ack_o was never held back by the slow consumer");
      report_test("output back-pressure");

      start_test();
      for (int k = 0; k < 3; k++)
         send_pair($urandom, $urandom, $urandom, $urandom);
      repeat (2) @(negedge clk);
      rst_n_i = 1'b0;
      repeat (4) @(negedge clk);
      check_val("ack_o", 64'(ack_o), 64'd0);
      check_val("res_req_o", 64'(res_req_o), 64'd0);
      rst_n_i = 1'b1;
      blk_n   = 0; // partial block was dropped by the reset.
      @(negedge clk);
      check_val("ack_o", 64'(ack_o), 64'd0);
      check_val("res_req_o", 64'(res_req_o), 64'd0);
      send_random_blocks(1);
      wait_results();
      report_test("reset mid-block");

      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
verilog/dot_pkg.sv
verilog/sample_rx.sv
verilog/cpx_multiply.sv
verilog/dot_accumulate.sv
verilog/result_tx.sv
verilog/dot_prod_top.sv
bench/dot_prod_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dot-product testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module dot_prod_tb -f tb.f -o dot_prod_sim

./obj_dir/dot_prod_sim > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
